// ==== build.f ====
+incdir+.
cx_core_pkg.sv
cx_fetch_unit.sv
cx_decoder.sv
cx_regfile.sv
cx_exec_ctrl.sv
cx_lsu.sv
cx_unit_port.sv
cx_core.sv
cx_core_assertions.sv
tb_cx_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the CX core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_cx_core \
  -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== tb_cx_core.sv ====
// CX core testbench
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module tb_cx_core;
  import cx_core_pkg::*;

  localparam logic [31:0] boot_addr = 32'h0000_1000;

  logic clk_i;
  logic rst_ni;
  logic fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic data_req_o, data_gnt_i, data_rvalid_i;
  logic [31:0] data_rdata_i;
  mem_cmd_t data_cmd_o;
  logic cx_req_valid_o, cx_resp_valid_i;
  logic [31:0] cx_resp_data_i;
  cx_req_t cx_req_o;

  logic [31:0] rom [64];
  logic [31:0] dmem [64];
  logic [31:0] sh_regs [32];
  logic [31:0] sh_mem [64];
  logic [31:0] sh_sel;
  logic [31:0] exp_st_addr [$];
  logic [31:0] exp_st_data [$];
  cx_req_t exp_cx [$];
  logic [31:0] lcg_state;
  logic [31:0] exp_pc;
  int prog_len;

  cx_core dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, lcg_state[31:16]};
  endfunction

  // Memory fill from the full byte address
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
  endfunction

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program builder with shadow execution
  ////////////////////////////////////////////////////////////////////////////

  task automatic emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
    if (rd != 5'd0) sh_regs[rd] = val;
  endtask

  task automatic add_immediate(input logic [4:0] rd, input logic [4:0] rs1,
                               input logic [11:0] imm);
    emit({imm, rs1, 3'b000, rd, `OPC_OP_IMM});
    write_reg(rd, sh_regs[rs1] + {{20{imm[11]}}, imm});
  endtask

  task automatic reg_reg_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    a = sh_regs[rs1];
    b = sh_regs[rs2];
    case ({f7, f3})
      10'b0100000_000: res = a - b;
      10'b0000000_111: res = a & b;
      10'b0000000_110: res = a | b;
      10'b0000000_100: res = a ^ b;
      default:         res = a + b;
    endcase
    emit({f7, rs2, rs1, f3, rd, `OPC_OP});
    write_reg(rd, res);
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] imm);
    logic [31:0] addr;
    addr = sh_regs[rs1] + {{20{imm[11]}}, imm};
    emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE});
    exp_st_addr.push_back(addr);
    exp_st_data.push_back(sh_regs[rs2]);
    sh_mem[addr[7:2]] = sh_regs[rs2];
  endtask

  task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
    logic [31:0] addr;
    addr = sh_regs[rs1] + {{20{imm[11]}}, imm};
    emit({imm, rs1, 3'b010, rd, `OPC_LOAD});
    write_reg(rd, sh_mem[addr[7:2]]);
  endtask

  // Only the unit and state fields of the selector exist
  task automatic swap_selector(input logic [4:0] rd, input logic [4:0] rs1);
    logic [31:0] old;
    old = sh_sel;
    emit({`CSR_CX_SEL, rs1, 3'b001, rd, `OPC_SYSTEM});
    sh_sel = sh_regs[rs1] & 32'h0000_0303;
    write_reg(rd, old);
  endtask

  task automatic cx_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                       input logic [4:0] rs1, input logic [4:0] rs2);
    cx_req_t req;
    req.cxu_id   = sh_sel[1:0];
    req.state_id = sh_sel[9:8];
    req.func     = {f7, f3};
    req.data0    = sh_regs[rs1];
    req.data1    = sh_regs[rs2];
    emit({f7, rs2, rs1, f3, rd, `OPC_CUSTOM0});
    exp_cx.push_back(req);
    write_reg(rd, (req.data0 + req.data1) ^ {22'd0, f7, f3});
  endtask

  task automatic build_program();
    for (int i = 0; i < 64; i++) begin
      rom[i]    = 32'h0000_0013;
      dmem[i]   = fill_word(32'(i * 4));
      sh_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) sh_regs[i] = 32'd0;
    sh_sel   = 32'd0;
    prog_len = 0;
    add_immediate(5'd1, 5'd0, 12'd100);
    add_immediate(5'd2, 5'd0, 12'hff9);
    reg_reg_op(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
    reg_reg_op(7'h20, 3'b000, 5'd4, 5'd1, 5'd2);
    reg_reg_op(7'h00, 3'b111, 5'd5, 5'd1, 5'd2);
    reg_reg_op(7'h00, 3'b110, 5'd6, 5'd1, 5'd2);
    reg_reg_op(7'h00, 3'b100, 5'd7, 5'd1, 5'd2);
    store_word(5'd3, 5'd0, 12'd0);
    store_word(5'd4, 5'd0, 12'd4);
    store_word(5'd5, 5'd0, 12'd8);
    store_word(5'd6, 5'd0, 12'd12);
    store_word(5'd7, 5'd0, 12'd16);
    load_word(5'd8, 5'd0, 12'd0);
    store_word(5'd8, 5'd0, 12'd20);
    load_word(5'd15, 5'd0, 12'd60);
    store_word(5'd15, 5'd0, 12'd44);
    add_immediate(5'd9, 5'd0, 12'h302);
    swap_selector(5'd10, 5'd9);
    cx_op(7'h05, 3'b011, 5'd11, 5'd1, 5'd2);
    store_word(5'd11, 5'd0, 12'd24);
    add_immediate(5'd12, 5'd0, 12'h101);
    swap_selector(5'd13, 5'd12);
    store_word(5'd13, 5'd0, 12'd28);
    cx_op(7'h12, 3'b110, 5'd14, 5'd3, 5'd4);
    store_word(5'd14, 5'd0, 12'd32);
    store_word(5'd10, 5'd0, 12'd36);
    // JAL is outside the subset and retires as a no-op
    emit(32'h0000_006f);
    store_word(5'd1, 5'd8, 12'd40);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory and CX responder models
  ////////////////////////////////////////////////////////////////////////////

  int i_gcnt, i_rcnt, d_gcnt, d_rcnt, cx_cnt;
  logic [31:0] i_addr, d_rdata, cx_data;

  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (instr_gnt_i && instr_req_o) begin
      check_value("instr_addr_o", exp_pc, instr_addr_o);
      exp_pc = exp_pc + 32'd4;
      i_addr = (instr_addr_o - boot_addr) >> 2;
      i_rcnt = 1 + int'(lcg_next() % 32'd3);
    end else if (i_rcnt > 0) begin
      i_rcnt--;
      if (i_rcnt == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= rom[i_addr[5:0]];
      end
    end else if (instr_req_o) begin
      if (i_gcnt < 0) i_gcnt = int'(lcg_next() % 32'd4);
      if (i_gcnt == 0) instr_gnt_i <= 1'b1;
      i_gcnt--;
    end
  end

  always @(posedge clk_i) begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    if (data_gnt_i && data_req_o) begin
      d_rdata = dmem[data_cmd_o.addr[7:2]];
      if (data_cmd_o.we) begin
        assert (exp_st_addr.size() > 0) else begin
          $display("Store issued after the last expected store");
          stop_run();
        end
        check_value("data_cmd_o.addr", exp_st_addr.pop_front(), data_cmd_o.addr);
        check_value("data_cmd_o.wdata", exp_st_data.pop_front(), data_cmd_o.wdata);
        dmem[data_cmd_o.addr[7:2]] = data_cmd_o.wdata;
      end
      d_rcnt = 1 + int'(lcg_next() % 32'd3);
    end else if (d_rcnt > 0) begin
      d_rcnt--;
      if (d_rcnt == 0) begin
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= d_rdata;
      end
    end else if (data_req_o) begin
      if (d_gcnt < 0) d_gcnt = int'(lcg_next() % 32'd4);
      if (d_gcnt == 0) data_gnt_i <= 1'b1;
      d_gcnt--;
    end
  end

  // CX responder answers data0 + data1 XOR func
  always @(posedge clk_i) begin
    cx_resp_valid_i <= 1'b0;
    if (cx_cnt > 0) begin
      cx_cnt--;
      if (cx_cnt == 0) begin
        cx_resp_valid_i <= 1'b1;
        cx_resp_data_i  <= cx_data;
      end
    end else if (cx_req_valid_o) begin
      assert (exp_cx.size() > 0) else begin
        $display("CX request issued with none expected");
        stop_run();
      end
      check_value("cx_req_o.cxu_id", 32'(exp_cx[0].cxu_id), 32'(cx_req_o.cxu_id));
      check_value("cx_req_o.state_id", 32'(exp_cx[0].state_id), 32'(cx_req_o.state_id));
      check_value("cx_req_o.func", 32'(exp_cx[0].func), 32'(cx_req_o.func));
      check_value("cx_req_o.data0", exp_cx[0].data0, cx_req_o.data0);
      check_value("cx_req_o.data1", exp_cx[0].data1, cx_req_o.data1);
      void'(exp_cx.pop_front());
      cx_data = (cx_req_o.data0 + cx_req_o.data1) ^ 32'(cx_req_o.func);
      cx_cnt  = 1 + int'(lcg_next() % 32'd4);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int cycles;
    int limit;
    lcg_state = 32'h1a98;
    exp_pc = boot_addr;
    i_gcnt = -1;
    i_rcnt = 0;
    d_gcnt = -1;
    d_rcnt = 0;
    cx_cnt = 0;
    rst_ni = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i = boot_addr;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = 32'd0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i = 32'd0;
    cx_resp_valid_i = 1'b0;
    cx_resp_data_i = 32'd0;
    build_program();
    limit = 40 * prog_len;
    cycles = 0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) begin
      @(posedge clk_i);
      assert (!instr_req_o && !data_req_o && !cx_req_valid_o) else begin
        $display("Request raised while fetch enable was low");
        stop_run();
      end
    end
    fetch_enable_i <= 1'b1;
    while (exp_st_addr.size() > 0 || exp_cx.size() > 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= limit) begin
        $display("Timeout after %0d cycles with work outstanding", cycles);
        $display("TB FAILED");
        $fatal(1);
      end
    end
    if (dut_i.asrt_i.err_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1);
    end
  end

endmodule

// ==== cx_core_assertions.sv ====
// CX core port protocol checks
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_core_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  instr_req_o,
  input logic [`XLEN-1:0]      instr_addr_o,
  input logic                  instr_gnt_i,
  input logic                  data_req_o,
  input cx_core_pkg::mem_cmd_t data_cmd_o,
  input logic                  data_gnt_i,
  input logic                  cx_req_valid_o
);

  // Number of failed checks
  int unsigned err_cnt = 0;

  // All requests stay low while in reset
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_ni |-> !instr_req_o && !data_req_o && !cx_req_valid_o)
    else begin
      err_cnt++;
      $error("Request active during reset");
    end

  a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      err_cnt++;
      $error("Instruction request dropped or changed before grant");
    end

  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_cmd_o))
    else begin
      err_cnt++;
      $error("Data request dropped or changed before grant");
    end

  // CX request is a single-cycle strobe
  a_cx_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cx_req_valid_o |=> !cx_req_valid_o)
    else begin
      err_cnt++;
      $error("CX request valid longer than one cycle");
    end

  // One instruction in flight
  a_one_port: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(instr_req_o && data_req_o))
    else begin
      err_cnt++;
      $error("Instruction and data requests overlap");
    end

endmodule

bind cx_core cx_core_assertions asrt_i (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .instr_req_o    ( instr_req_o    ),
  .instr_addr_o   ( instr_addr_o   ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .data_req_o     ( data_req_o     ),
  .data_cmd_o     ( data_cmd_o     ),
  .data_gnt_i     ( data_gnt_i     ),
  .cx_req_valid_o ( cx_req_valid_o )
);

// ==== cx_core.sv ====
// CX core top level
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_core (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic [`XLEN-1:0]      boot_addr_i,
  // Instruction port
  output logic                  instr_req_o,
  output logic [`XLEN-1:0]      instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`XLEN-1:0]      instr_rdata_i,
  // Data port
  output logic                  data_req_o,
  output cx_core_pkg::mem_cmd_t data_cmd_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`XLEN-1:0]      data_rdata_i,
  // CX port
  output logic                  cx_req_valid_o,
  output cx_core_pkg::cx_req_t  cx_req_o,
  input  logic                  cx_resp_valid_i,
  input  logic [`XLEN-1:0]      cx_resp_data_i
);
  import cx_core_pkg::*;

  // Fetch and decode
  logic                   fetch_start;
  logic                   fetch_done;
  logic                   retire;
  logic [`XLEN-1:0]       instr;
  exec_ctrl_t             dec_ctrl;

  // Register file
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  logic                   rf_we;
  logic [`REG_ADDR_W-1:0] rf_waddr;
  logic [`XLEN-1:0]       rf_wdata;

  // Load-store and CX
  logic                   mem_start;
  mem_cmd_t               mem_cmd;
  logic                   mem_done;
  logic [`XLEN-1:0]       mem_rdata;
  logic                   cx_start;
  logic                   cx_done;
  logic [`XLEN-1:0]       cx_rdata;
  logic                   csr_we;
  logic [`XLEN-1:0]       csr_wdata;
  logic [`XLEN-1:0]       csr_rdata;

  cx_fetch_unit fetch_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_start_i  ( fetch_start    ),
    .retire_i       ( retire         ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_done_o   ( fetch_done     ),
    .instr_o        ( instr          ),
    .pc_o           (                )
  );

  cx_decoder decoder_i (
    .instr_i ( instr    ),
    .ctrl_o  ( dec_ctrl )
  );

  // Source fields stay valid while the fetched word is held
  cx_regfile regfile_i (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .raddr_a_i ( dec_ctrl.rs1 ),
    .raddr_b_i ( dec_ctrl.rs2 ),
    .rdata_a_o ( rs1_data     ),
    .rdata_b_o ( rs2_data     ),
    .we_i      ( rf_we        ),
    .waddr_i   ( rf_waddr     ),
    .wdata_i   ( rf_wdata     )
  );

  cx_exec_ctrl exec_ctrl_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_start_o  ( fetch_start    ),
    .fetch_done_i   ( fetch_done     ),
    .ctrl_i         ( dec_ctrl       ),
    .retire_o       ( retire         ),
    .rs1_data_i     ( rs1_data       ),
    .rs2_data_i     ( rs2_data       ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .mem_start_o    ( mem_start      ),
    .mem_cmd_o      ( mem_cmd        ),
    .mem_done_i     ( mem_done       ),
    .mem_rdata_i    ( mem_rdata      ),
    .cx_start_o     ( cx_start       ),
    .cx_done_i      ( cx_done        ),
    .cx_rdata_i     ( cx_rdata       ),
    .csr_we_o       ( csr_we         ),
    .csr_wdata_o    ( csr_wdata      ),
    .csr_rdata_i    ( csr_rdata      )
  );

  cx_lsu lsu_i (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .mem_start_i   ( mem_start     ),
    .mem_cmd_i     ( mem_cmd       ),
    .mem_done_o    ( mem_done      ),
    .mem_rdata_o   ( mem_rdata     ),
    .data_req_o    ( data_req_o    ),
    .data_cmd_o    ( data_cmd_o    ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  )
  );

  cx_unit_port cx_port_i (
    .clk_i           ( clk_i            ),
    .rst_ni          ( rst_ni           ),
    .csr_we_i        ( csr_we           ),
    .csr_wdata_i     ( csr_wdata        ),
    .csr_rdata_o     ( csr_rdata        ),
    .cx_start_i      ( cx_start         ),
    .func_i          ( dec_ctrl.cx_func ),
    .data0_i         ( rs1_data         ),
    .data1_i         ( rs2_data         ),
    .cx_done_o       ( cx_done          ),
    .cx_rdata_o      ( cx_rdata         ),
    .cx_req_valid_o  ( cx_req_valid_o   ),
    .cx_req_o        ( cx_req_o         ),
    .cx_resp_valid_i ( cx_resp_valid_i  ),
    .cx_resp_data_i  ( cx_resp_data_i   )
  );

endmodule

// ==== cx_unit_port.sv ====
// CX request port and selector CSR
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_unit_port (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Selector CSR access
  input  logic                  csr_we_i,
  input  logic [`XLEN-1:0]      csr_wdata_i,
  output logic [`XLEN-1:0]      csr_rdata_o,
  // From controller
  input  logic                  cx_start_i,
  input  logic [`CX_FUNC_W-1:0] func_i,
  input  logic [`XLEN-1:0]      data0_i,
  input  logic [`XLEN-1:0]      data1_i,
  output logic                  cx_done_o,
  output logic [`XLEN-1:0]      cx_rdata_o,
  // CX port
  output logic                  cx_req_valid_o,
  output cx_core_pkg::cx_req_t  cx_req_o,
  input  logic                  cx_resp_valid_i,
  input  logic [`XLEN-1:0]      cx_resp_data_i
);
  import cx_core_pkg::*;

  logic [`CX_ID_W-1:0] sel_cxu_q;
  logic [`CX_ID_W-1:0] sel_state_q;
  cx_req_t             req_q;
  logic [`XLEN-1:0]    rdata_q;
  logic                valid_q;
  logic                pend_q;
  logic                done_q;
  logic                resp_take;

  // Responses outside a pending request are dropped
  assign resp_take = pend_q && cx_resp_valid_i;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      sel_cxu_q   <= '0;
      sel_state_q <= '0;
      valid_q     <= 1'b0;
      pend_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      if (csr_we_i) begin
        sel_cxu_q   <= csr_wdata_i[`CX_SEL_CXU_LSB +: `CX_ID_W];
        sel_state_q <= csr_wdata_i[`CX_SEL_STATE_LSB +: `CX_ID_W];
      end
      valid_q <= cx_start_i;
      if (valid_q) begin
        pend_q <= 1'b1;
      end else if (resp_take) begin
        pend_q <= 1'b0;
      end
      done_q <= resp_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cx_start_i) begin
      req_q.cxu_id   <= sel_cxu_q;
      req_q.state_id <= sel_state_q;
      req_q.func     <= func_i;
      req_q.data0    <= data0_i;
      req_q.data1    <= data1_i;
    end
    if (resp_take) begin
      rdata_q <= cx_resp_data_i;
    end
  end

  // Unimplemented selector bits read as zero
  always_comb begin
    csr_rdata_o = '0;
    csr_rdata_o[`CX_SEL_CXU_LSB +: `CX_ID_W]   = sel_cxu_q;
    csr_rdata_o[`CX_SEL_STATE_LSB +: `CX_ID_W] = sel_state_q;
  end

  assign cx_req_valid_o = valid_q;
  assign cx_req_o       = req_q;
  assign cx_done_o      = done_q;
  assign cx_rdata_o     = rdata_q;

endmodule

// ==== cx_lsu.sv ====
// Load-store unit
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_lsu (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  mem_start_i,
  input  cx_core_pkg::mem_cmd_t mem_cmd_i,
  output logic                  mem_done_o,
  output logic [`XLEN-1:0]      mem_rdata_o,
  // Data port
  output logic                  data_req_o,
  output cx_core_pkg::mem_cmd_t data_cmd_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  logic [`XLEN-1:0]      data_rdata_i
);
  import cx_core_pkg::*;

  mem_cmd_t         cmd_q;
  logic [`XLEN-1:0] rdata_q;
  logic             req_q;
  logic             wait_q;
  logic             done_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (mem_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        req_q <= 1'b0;
      end
      // Stores wait for rvalid as well
      if (req_q && data_gnt_i) begin
        wait_q <= 1'b1;
      end else if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
      end
      done_q <= wait_q && data_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_start_i) begin
      cmd_q <= mem_cmd_i;
    end
    if (wait_q && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o  = req_q;
  assign data_cmd_o  = cmd_q;
  assign mem_done_o  = done_q;
  assign mem_rdata_o = rdata_q;

endmodule

// ==== cx_exec_ctrl.sv ====
// Core controller and ALU
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_exec_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fetch_enable_i,
  // Fetch
  output logic                    fetch_start_o,
  input  logic                    fetch_done_i,
  input  cx_core_pkg::exec_ctrl_t ctrl_i,
  output logic                    retire_o,
  // Register file
  input  logic [`XLEN-1:0]        rs1_data_i,
  input  logic [`XLEN-1:0]        rs2_data_i,
  output logic                    rf_we_o,
  output logic [`REG_ADDR_W-1:0]  rf_waddr_o,
  output logic [`XLEN-1:0]        rf_wdata_o,
  // Load-store unit
  output logic                    mem_start_o,
  output cx_core_pkg::mem_cmd_t   mem_cmd_o,
  input  logic                    mem_done_i,
  input  logic [`XLEN-1:0]        mem_rdata_i,
  // CX port and selector CSR
  output logic                    cx_start_o,
  input  logic                    cx_done_i,
  input  logic [`XLEN-1:0]        cx_rdata_i,
  output logic                    csr_we_o,
  output logic [`XLEN-1:0]        csr_wdata_o,
  input  logic [`XLEN-1:0]        csr_rdata_i
);
  import cx_core_pkg::*;

  core_state_e      state_q;
  core_state_e      state_d;
  exec_ctrl_t       ctrl_q;
  logic             start_q;
  logic             in_exec;
  logic             single_cycle;
  logic             mem_end;
  logic             cx_end;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (fetch_enable_i) state_d = ST_FETCH;
      ST_FETCH: if (fetch_done_i) state_d = ST_EXEC;
      ST_EXEC: begin
        if (ctrl_q.op_class == OP_LOAD || ctrl_q.op_class == OP_STORE) begin
          state_d = ST_MEM;
        end else if (ctrl_q.op_class == OP_CX) begin
          state_d = ST_CX;
        end else begin
          state_d = ST_FETCH;
        end
      end
      ST_MEM:   if (mem_done_i) state_d = ST_FETCH;
      ST_CX:    if (cx_done_i) state_d = ST_FETCH;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Fetch after enable or a multi-cycle completion starts one cycle late
      start_q <= (state_d == ST_FETCH) &&
                 (state_q == ST_IDLE || state_q == ST_MEM || state_q == ST_CX);
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_done_i) begin
      ctrl_q <= ctrl_i;
    end
  end

  assign in_exec      = (state_q == ST_EXEC);
  assign single_cycle = (ctrl_q.op_class == OP_ALU_R) || (ctrl_q.op_class == OP_ALU_I) ||
                        (ctrl_q.op_class == OP_CSRRW) || (ctrl_q.op_class == OP_NOP);
  assign mem_end      = (state_q == ST_MEM) && mem_done_i;
  assign cx_end       = (state_q == ST_CX) && cx_done_i;

  assign fetch_start_o = start_q || (in_exec && single_cycle);
  assign retire_o      = (in_exec && single_cycle) || mem_end || cx_end;
  assign mem_start_o   = in_exec && (ctrl_q.op_class == OP_LOAD || ctrl_q.op_class == OP_STORE);
  assign cx_start_o    = in_exec && (ctrl_q.op_class == OP_CX);
  assign csr_we_o      = in_exec && (ctrl_q.op_class == OP_CSRRW);
  assign csr_wdata_o   = rs1_data_i;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and writeback
  ////////////////////////////////////////////////////////////////////////////

  assign alu_b = (ctrl_q.op_class == OP_ALU_I) ? ctrl_q.imm : rs2_data_i;

  always_comb begin
    case (ctrl_q.alu_op)
      ALU_SUB: alu_res = rs1_data_i - alu_b;
      ALU_AND: alu_res = rs1_data_i & alu_b;
      ALU_OR:  alu_res = rs1_data_i | alu_b;
      ALU_XOR: alu_res = rs1_data_i ^ alu_b;
      default: alu_res = rs1_data_i + alu_b;
    endcase
  end

  assign mem_cmd_o.we    = (ctrl_q.op_class == OP_STORE);
  assign mem_cmd_o.addr  = rs1_data_i + ctrl_q.imm;
  assign mem_cmd_o.wdata = rs2_data_i;

  // CSRRW returns the old selector value
  always_comb begin
    case (ctrl_q.op_class)
      OP_LOAD:  rf_wdata_o = mem_rdata_i;
      OP_CX:    rf_wdata_o = cx_rdata_i;
      OP_CSRRW: rf_wdata_o = csr_rdata_i;
      default:  rf_wdata_o = alu_res;
    endcase
  end

  assign rf_we_o    = (in_exec && (ctrl_q.op_class == OP_ALU_R || ctrl_q.op_class == OP_ALU_I ||
                                   ctrl_q.op_class == OP_CSRRW)) ||
                      (mem_end && ctrl_q.op_class == OP_LOAD) || cx_end;
  assign rf_waddr_o = ctrl_q.rd;

endmodule

// ==== cx_regfile.sv ====
// Integer register file
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  // x0 has no storage
  logic [`XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== cx_decoder.sv ====
// Instruction decoder
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_decoder (
  input  logic [`XLEN-1:0]      instr_i,
  output cx_core_pkg::exec_ctrl_t ctrl_o
);
  import cx_core_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic [`XLEN-1:0] imm_i_type;
  logic [`XLEN-1:0] imm_s_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  always_comb begin
    ctrl_o.op_class = OP_NOP;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.rd       = instr_i[11:7];
    ctrl_o.rs1      = instr_i[19:15];
    ctrl_o.rs2      = instr_i[24:20];
    ctrl_o.imm      = imm_i_type;
    ctrl_o.cx_func  = {funct7, funct3};
    ctrl_o.csr      = instr_i[31:20];

    case (opcode)
      `OPC_OP: begin
        ctrl_o.op_class = OP_ALU_R;
        case ({funct7, funct3})
          10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
          10'b0000000_111: ctrl_o.alu_op = ALU_AND;
          10'b0000000_110: ctrl_o.alu_op = ALU_OR;
          10'b0000000_100: ctrl_o.alu_op = ALU_XOR;
          default:         ctrl_o.op_class = OP_NOP;
        endcase
      end
      `OPC_OP_IMM: begin
        // ADDI only
        if (funct3 == 3'b000) begin
          ctrl_o.op_class = OP_ALU_I;
        end
      end
      `OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          ctrl_o.op_class = OP_LOAD;
        end
      end
      `OPC_STORE: begin
        if (funct3 == 3'b010) begin
          ctrl_o.op_class = OP_STORE;
          ctrl_o.imm      = imm_s_type;
        end
      end
      `OPC_SYSTEM: begin
        if (funct3 == 3'b001 && ctrl_o.csr == `CSR_CX_SEL) begin
          ctrl_o.op_class = OP_CSRRW;
        end
      end
      `OPC_CUSTOM0: ctrl_o.op_class = OP_CX;
      default:      ctrl_o.op_class = OP_NOP;
    endcase
  end

endmodule

// ==== cx_fetch_unit.sv ====
// Instruction fetch unit
`timescale 1ns/1ns
`include "cx_core_macros.svh"

module cx_fetch_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`XLEN-1:0] boot_addr_i,
  input  logic             fetch_start_i,
  input  logic             retire_i,
  // Instruction port
  output logic             instr_req_o,
  output logic [`XLEN-1:0] instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  // To controller and decoder
  output logic             fetch_done_o,
  output logic [`XLEN-1:0] instr_o,
  output logic [`XLEN-1:0] pc_o
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] instr_q;
  logic             req_q;
  logic             wait_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q   <= boot_addr_i;
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (retire_i) begin
        pc_q <= pc_q + `XLEN'(4);
      end
      // Request holds until granted
      if (fetch_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && instr_gnt_i) begin
        req_q <= 1'b0;
      end
      if (req_q && instr_gnt_i) begin
        wait_q <= 1'b1;
      end else if (fetch_done_o) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Word is kept so the decoder output stays valid after rvalid
  always_ff @(posedge clk_i) begin
    if (fetch_done_o) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign fetch_done_o = wait_q && instr_rvalid_i;
  assign instr_o      = fetch_done_o ? instr_rdata_i : instr_q;
  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;
  assign pc_o         = pc_q;

endmodule

// ==== cx_core_pkg.sv ====
// CX core types
`include "cx_core_macros.svh"

package cx_core_pkg;

  // Instruction class after decode
  typedef enum logic [2:0] {
    OP_NOP,
    OP_ALU_R,
    OP_ALU_I,
    OP_LOAD,
    OP_STORE,
    OP_CSRRW,
    OP_CX
  } op_class_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_CX
  } core_state_e;

  // Decoded instruction
  typedef struct packed {
    op_class_e              op_class;
    alu_op_e                alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic [`CX_FUNC_W-1:0]  cx_func;
    logic [11:0]            csr;
  } exec_ctrl_t;

  // One data port access, always a whole word
  typedef struct packed {
    logic             we;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } mem_cmd_t;

  typedef struct packed {
    logic [`CX_ID_W-1:0]   cxu_id;
    logic [`CX_ID_W-1:0]   state_id;
    logic [`CX_FUNC_W-1:0] func;
    logic [`XLEN-1:0]      data0;
    logic [`XLEN-1:0]      data1;
  } cx_req_t;

endpackage

// ==== cx_core_macros.svh ====
// CX core shared constants
`ifndef CX_CORE_MACROS_SVH
`define CX_CORE_MACROS_SVH

// Datapath and register index widths
`define XLEN       32
`define REG_ADDR_W 5

// CX function is funct7 followed by funct3
`define CX_FUNC_W 10
`define CX_ID_W   2

// CX selector CSR and its field positions
`define CSR_CX_SEL         12'hBC0
`define CX_SEL_CXU_LSB     0
`define CX_SEL_STATE_LSB   8

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_SYSTEM  7'b1110011
`define OPC_CUSTOM0 7'b0001011

`endif
